/* src/fse_fmt_pkg.sv */
`default_nettype none

package fse_fmt_pkg;

  // Input samples, S(8,7)
  localparam int NBT_IN = 8;
  localparam int NBF_IN = 7;

  // Tap formats inside the LMS block and as seen by the filter
  localparam int NBT_LMS_TAPS = 20;  // S(20,17)
  localparam int NBF_LMS_TAPS = 17;
  localparam int NBT_FSE_TAPS = 10;  // S(10,7)
  localparam int NBF_FSE_TAPS = 7;

  // Slicer error, S(9,7)
  localparam int NBT_ERR = 9;
  localparam int NBF_ERR = 7;

  // Filter output after rounding, S(12,9)
  localparam int NBT_Y = 12;
  localparam int NBF_Y = 9;

  typedef logic signed [NBT_IN-1:0]       sample_t;
  typedef logic signed [NBT_ERR-1:0]      err_t;
  typedef logic signed [NBT_LMS_TAPS-1:0] lms_tap_t;
  typedef logic signed [NBT_FSE_TAPS-1:0] fse_tap_t;
  typedef logic signed [NBT_Y-1:0]        y_t;
  typedef logic signed [NBT_ERR-1:0]      dec_t;  // Same grid as the error

endpackage

`default_nettype wire

/* src/fse_ctrl_pkg.sv */
`default_nettype none

package fse_ctrl_pkg;

  // Two samples per symbol, the odd one closes the symbol
  typedef enum logic {
    PH_EVEN = 1'b0,
    PH_ODD  = 1'b1
  } rx_phase_e;

  // Delays counted from the shift of the closing sample
  localparam int SAVE_DLY = 1;  // Buffer save, filter capture
  localparam int TAP_DLY  = 3;  // Slicer error is valid here

endpackage

`default_nettype wire

/* src/fse_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Strobes from the rate controller to filter and LMS
interface lms_ctrl_if;
  logic en_shtr;      // Shift in a new sample
  logic save_shftrs;  // Freeze the symbol window
  logic en_taps;      // Load updated taps
  logic en_rx;        // Level, low holds everything idle

  modport master (output en_shtr, output save_shftrs, output en_taps, output en_rx);
  modport slave  (input en_shtr, input save_shftrs, input en_taps, input en_rx);
endinterface

// One symbol result from the slicer
interface sym_if
  import fse_fmt_pkg::*;
();
  logic valid;
  dec_t dec_I;
  dec_t dec_Q;
  err_t err_I;
  err_t err_Q;

  modport master (
    output valid, output dec_I, output dec_Q,
    output err_I, output err_Q
  );
  modport slave (
    input valid, input dec_I, input dec_Q,
    input err_I, input err_Q
  );
endinterface

`default_nettype wire

/* src/fse_rate_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fse_rate_ctrl
  import fse_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       i_rst_n,
  input  logic       i_valid,
  lms_ctrl_if.master o_ctrl,
  input  logic       i_en_rx
);

  rx_phase_e        r_phase;
  logic [TAP_DLY:1] r_mark;   // Symbol marker, bit n is n cycles after the shift
  logic             w_shift;
  logic             w_close;

  assign w_shift = i_valid & i_en_rx;
  assign w_close = w_shift && (r_phase == PH_ODD);

  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_en_rx) begin
      r_phase <= PH_EVEN;
      r_mark  <= '0;
    end else begin
      if (w_shift) begin
        r_phase <= (r_phase == PH_EVEN) ? PH_ODD : PH_EVEN;
      end
      r_mark <= {r_mark[TAP_DLY-1:1], w_close};
    end
  end

  // Shift happens in the same cycle as the strobe
  assign o_ctrl.en_shtr     = w_shift;
  assign o_ctrl.save_shftrs = r_mark[SAVE_DLY];
  assign o_ctrl.en_taps     = r_mark[TAP_DLY];
  assign o_ctrl.en_rx       = i_en_rx;

endmodule

`default_nettype wire

/* src/fse_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module fse_filter
  import fse_fmt_pkg::*;
#(
  parameter int NUM_TAPS = 9
)
(
  input  logic                     clk,
  input  logic                     i_rst_n,
  lms_ctrl_if.slave                i_ctrl,
  input  sample_t                  i_data_I,
  input  sample_t                  i_data_Q,
  input  fse_tap_t [NUM_TAPS-1:0]  i_taps_I,
  input  fse_tap_t [NUM_TAPS-1:0]  i_taps_Q,
  output y_t                       o_y_I,
  output y_t                       o_y_Q
);

  localparam int NBF_ACC = NBF_IN + NBF_FSE_TAPS;
  localparam int NBT_ACC = NBT_IN + NBT_FSE_TAPS + $clog2(2 * NUM_TAPS);
  localparam int NBT_RND = NBT_ACC + 1;         // Headroom for the rounding add
  localparam int DROP    = NBF_ACC - NBF_Y;
  localparam int NB_SAT  = NBT_RND - DROP - NBT_Y;

  sample_t                   r_line_I [NUM_TAPS];
  sample_t                   r_line_Q [NUM_TAPS];
  logic signed [NBT_ACC-1:0] w_acc_I;
  logic signed [NBT_ACC-1:0] w_acc_Q;

  // Round half up to S(12,9), clip on overflow
  function automatic y_t round_sat(input logic signed [NBT_ACC-1:0] acc);
    logic signed [NBT_RND-1:0] rnd;
    logic [NB_SAT:0]           top;
    rnd = NBT_RND'(acc) + (NBT_RND'(1) <<< (DROP - 1));
    top = rnd[NBT_RND-1 -: NB_SAT+1];
    if (&top || ~|top) begin
      return rnd[DROP +: NBT_Y];
    end
    return top[NB_SAT] ? {1'b1, {(NBT_Y-1){1'b0}}} : {1'b0, {(NBT_Y-1){1'b1}}};
  endfunction

  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_ctrl.en_rx) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        r_line_I[k] <= '0;
        r_line_Q[k] <= '0;
      end
    end else if (i_ctrl.en_shtr) begin
      r_line_I[0] <= i_data_I;  // Newest sample at index 0
      r_line_Q[0] <= i_data_Q;
      for (int k = 1; k < NUM_TAPS; k++) begin
        r_line_I[k] <= r_line_I[k-1];
        r_line_Q[k] <= r_line_Q[k-1];
      end
    end
  end

  // Complex sum of products, y = sum(c[k] * x[k])
  always_comb begin
    w_acc_I = '0;
    w_acc_Q = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      w_acc_I = w_acc_I + $signed(i_taps_I[k]) * r_line_I[k]
                        - $signed(i_taps_Q[k]) * r_line_Q[k];
      w_acc_Q = w_acc_Q + $signed(i_taps_I[k]) * r_line_Q[k]
                        + $signed(i_taps_Q[k]) * r_line_I[k];
    end
  end

  // One output per symbol, taken on the save cycle
  always_ff @(posedge clk) begin
    if (i_ctrl.save_shftrs) begin
      o_y_I <= round_sat(w_acc_I);
      o_y_Q <= round_sat(w_acc_Q);
    end
  end

endmodule

`default_nettype wire

/* src/fse_slicer.sv */
`timescale 1ns/1ps
`default_nettype none

module fse_slicer
  import fse_fmt_pkg::*;
(
  input  logic  clk,
  input  logic  i_rst_n,
  input  y_t    i_y_I,
  input  y_t    i_y_Q,
  input  logic  i_y_strobe,
  sym_if.master o_sym
);

  localparam int SHIFT    = NBF_Y - NBF_ERR;
  localparam int NBT_DIFF = NBT_Y + 2;
  localparam int NB_SAT   = NBT_DIFF - SHIFT - NBT_ERR;
  localparam dec_t DEC_POS = dec_t'(1 <<< (NBF_ERR - 1));  // +0.5
  localparam dec_t DEC_NEG = -DEC_POS;

  logic r_valid;
  dec_t w_dec_I;
  dec_t w_dec_Q;
  dec_t r_dec_I;
  dec_t r_dec_Q;
  err_t r_err_I;
  err_t r_err_Q;

  function automatic dec_t decide(input y_t y);
    return y[NBT_Y-1] ? DEC_NEG : DEC_POS;
  endfunction

  // Error is y minus decision, brought to S(9,7)
  function automatic err_t slice_err(input y_t y, input dec_t d);
    logic signed [NBT_DIFF-1:0] diff;
    logic [NB_SAT:0]            top;
    diff = NBT_DIFF'(y) - (NBT_DIFF'(d) <<< SHIFT) + (NBT_DIFF'(1) <<< (SHIFT - 1));
    top  = diff[NBT_DIFF-1 -: NB_SAT+1];
    if (&top || ~|top) begin
      return diff[SHIFT +: NBT_ERR];
    end
    return top[NB_SAT] ? {1'b1, {(NBT_ERR-1){1'b0}}} : {1'b0, {(NBT_ERR-1){1'b1}}};
  endfunction

  assign w_dec_I = decide(i_y_I);
  assign w_dec_Q = decide(i_y_Q);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_y_strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (i_y_strobe) begin
      r_dec_I <= w_dec_I;
      r_dec_Q <= w_dec_Q;
      r_err_I <= slice_err(i_y_I, w_dec_I);
      r_err_Q <= slice_err(i_y_Q, w_dec_Q);
    end
  end

  assign o_sym.valid = r_valid;
  assign o_sym.dec_I = r_dec_I;
  assign o_sym.dec_Q = r_dec_Q;
  assign o_sym.err_I = r_err_I;
  assign o_sym.err_Q = r_err_Q;

endmodule

`default_nettype wire

/* src/lms_update.sv */
`timescale 1ns/1ps
`default_nettype none

module lms_update
  import fse_fmt_pkg::*;
#(
  parameter int                 NUM_TAPS = 9,
  parameter logic signed [11:0] STEP     = 12'sd1,  // S(12,11)
  parameter logic signed [10:0] LEAK     = 11'sd1   // S(11,10)
)
(
  input  logic                     clk,
  input  logic                     i_rst_n,
  lms_ctrl_if.slave                i_ctrl,
  input  sample_t                  i_data_I,
  input  sample_t                  i_data_Q,
  input  err_t                     i_err_I,
  input  err_t                     i_err_Q,
  output fse_tap_t [NUM_TAPS-1:0]  o_taps_I,
  output fse_tap_t [NUM_TAPS-1:0]  o_taps_Q
);

  localparam int NBT_STEP = $bits(STEP);
  localparam int NBT_LEAK = $bits(LEAK);
  localparam int NBT_GAIN = NBT_STEP + NBT_LEAK;
  localparam int NBF_GAIN = (NBT_STEP - 1) + (NBT_LEAK - 1);

  // tap * (1 - step*leak)
  localparam int NBT_T1 = NBT_LMS_TAPS + NBT_GAIN;
  localparam int NBF_T1 = NBF_LMS_TAPS + NBF_GAIN;
  // step * (e * x), the extra bit holds the sum of two products
  localparam int NBT_T2 = NBT_STEP + NBT_ERR + NBT_IN + 1;
  localparam int NBF_T2 = (NBT_STEP - 1) + NBF_ERR + NBF_IN;

  localparam int ALIGN   = NBF_T1 - NBF_T2;
  localparam int NBT_SUM = ((NBT_T1 > NBT_T2 + ALIGN) ? NBT_T1 : NBT_T2 + ALIGN) + 1;
  localparam int DROP    = NBF_T1 - NBF_LMS_TAPS;
  localparam int NB_SAT  = NBT_SUM - DROP - NBT_LMS_TAPS;
  localparam int MID_IDX = NUM_TAPS / 2;

  localparam logic signed [NBT_GAIN-1:0] ONE  = NBT_GAIN'(1) <<< NBF_GAIN;
  localparam logic signed [NBT_GAIN-1:0] GAIN = ONE - STEP * LEAK;
  localparam lms_tap_t TAP_ONE = lms_tap_t'(1) <<< NBF_LMS_TAPS;
  localparam lms_tap_t TAP_MAX = {1'b0, {(NBT_LMS_TAPS-1){1'b1}}};
  localparam lms_tap_t TAP_MIN = {1'b1, {(NBT_LMS_TAPS-1){1'b0}}};

  sample_t  r_shift_I [NUM_TAPS];  // Runs at the sample rate
  sample_t  r_shift_Q [NUM_TAPS];
  sample_t  r_buf_I   [NUM_TAPS];  // Window of the last symbol instant
  sample_t  r_buf_Q   [NUM_TAPS];
  lms_tap_t r_taps_I  [NUM_TAPS];
  lms_tap_t r_taps_Q  [NUM_TAPS];
  lms_tap_t w_new_I   [NUM_TAPS];
  lms_tap_t w_new_Q   [NUM_TAPS];

  // Leaky step on one tap, truncated to S(20,17) and clipped
  function automatic lms_tap_t leaky_step(input lms_tap_t                 tap,
                                          input logic signed [NBT_T2-1:0] grad,
                                          input logic                     sub);
    logic signed [NBT_T1-1:0]  t1;
    logic signed [NBT_SUM-1:0] g_al;
    logic signed [NBT_SUM-1:0] sum;
    logic [NB_SAT:0]           top;
    t1   = tap * GAIN;
    g_al = NBT_SUM'(grad) <<< ALIGN;
    sum  = sub ? NBT_SUM'(t1) - g_al : NBT_SUM'(t1) + g_al;
    top  = sum[NBT_SUM-1 -: NB_SAT+1];
    if (&top || ~|top) begin
      return sum[DROP +: NBT_LMS_TAPS];
    end
    return top[NB_SAT] ? TAP_MIN : TAP_MAX;
  endfunction

  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_ctrl.en_rx) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        r_shift_I[k] <= '0;
        r_shift_Q[k] <= '0;
        r_buf_I[k]   <= '0;
        r_buf_Q[k]   <= '0;
      end
    end else begin
      if (i_ctrl.en_shtr) begin
        r_shift_I[0] <= i_data_I;
        r_shift_Q[0] <= i_data_Q;
        for (int k = 1; k < NUM_TAPS; k++) begin
          r_shift_I[k] <= r_shift_I[k-1];
          r_shift_Q[k] <= r_shift_Q[k-1];
        end
      end
      // Held until the error for this symbol arrives
      if (i_ctrl.save_shftrs) begin
        r_buf_I <= r_shift_I;
        r_buf_Q <= r_shift_Q;
      end
    end
  end

  // Start from 1+j0 at the centre
  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_ctrl.en_rx) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        r_taps_I[k] <= (k == MID_IDX) ? TAP_ONE : '0;
        r_taps_Q[k] <= '0;
      end
    end else if (i_ctrl.en_taps) begin
      r_taps_I <= w_new_I;
      r_taps_Q <= w_new_Q;
    end
  end

  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
    logic signed [NBT_T2-1:0] w_grad_I;
    logic signed [NBT_T2-1:0] w_grad_Q;

    assign w_grad_I = STEP * (i_err_I * r_buf_I[k] + i_err_Q * r_buf_Q[k]);
    assign w_grad_Q = STEP * (i_err_I * r_buf_Q[k] - i_err_Q * r_buf_I[k]);

    assign w_new_I[k] = leaky_step(r_taps_I[k], w_grad_I, 1'b1);  // I moves against the gradient
    assign w_new_Q[k] = leaky_step(r_taps_Q[k], w_grad_Q, 1'b0);

    // Upper bits give S(10,7)
    assign o_taps_I[k] = r_taps_I[k][NBT_LMS_TAPS-1 -: NBT_FSE_TAPS];
    assign o_taps_Q[k] = r_taps_Q[k][NBT_LMS_TAPS-1 -: NBT_FSE_TAPS];
  end

endmodule

`default_nettype wire

/* src/fse_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fse_top
  import fse_fmt_pkg::*;
#(
  parameter int                 NUM_TAPS = 9,
  parameter logic signed [11:0] STEP     = 12'sd1,
  parameter logic signed [10:0] LEAK     = 11'sd1
)
(
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_en_rx,
  input  logic                     i_valid,
  input  sample_t                  i_data_I,
  input  sample_t                  i_data_Q,
  output logic                     o_sym_valid,
  output dec_t                     o_dec_I,
  output dec_t                     o_dec_Q,
  output err_t                     o_err_I,
  output err_t                     o_err_Q,
  output fse_tap_t [NUM_TAPS-1:0]  o_taps_I,
  output fse_tap_t [NUM_TAPS-1:0]  o_taps_Q
);

  lms_ctrl_if u_ctrl_if ();
  sym_if      u_sym_if ();

  y_t   w_y_I;
  y_t   w_y_Q;
  logic r_y_strobe;  // Filter output is stable one cycle after the save

  always_ff @(posedge clk) begin
    if (!i_rst_n || !i_en_rx) begin
      r_y_strobe <= 1'b0;
    end else begin
      r_y_strobe <= u_ctrl_if.save_shftrs;
    end
  end

  fse_rate_ctrl u_rate_ctrl (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .o_ctrl  (u_ctrl_if.master),
    .i_en_rx (i_en_rx)
  );

  fse_filter #(.NUM_TAPS(NUM_TAPS)) u_filter (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_ctrl   (u_ctrl_if.slave),
    .i_data_I (i_data_I),
    .i_data_Q (i_data_Q),
    .i_taps_I (o_taps_I),
    .i_taps_Q (o_taps_Q),
    .o_y_I    (w_y_I),
    .o_y_Q    (w_y_Q)
  );

  fse_slicer u_slicer (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_y_I      (w_y_I),
    .i_y_Q      (w_y_Q),
    .i_y_strobe (r_y_strobe),
    .o_sym      (u_sym_if.master)
  );

  lms_update #(.NUM_TAPS(NUM_TAPS), .STEP(STEP), .LEAK(LEAK)) u_lms (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_ctrl   (u_ctrl_if.slave),
    .i_data_I (i_data_I),
    .i_data_Q (i_data_Q),
    .i_err_I  (u_sym_if.err_I),
    .i_err_Q  (u_sym_if.err_Q),
    .o_taps_I (o_taps_I),
    .o_taps_Q (o_taps_Q)
  );

  assign o_sym_valid = u_sym_if.valid;
  assign o_dec_I     = u_sym_if.dec_I;
  assign o_dec_Q     = u_sym_if.dec_Q;
  assign o_err_I     = u_sym_if.err_I;
  assign o_err_Q     = u_sym_if.err_Q;

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int RST_CYCLES = 16
)
(
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;  // 10 ns period
  end

  // Released just after an edge, so the DUT sees a clean synchronous release
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_fse.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fse
  import fse_fmt_pkg::*;
;

  localparam int NUM_TAPS      = 9;
  localparam int MID_IDX       = NUM_TAPS / 2;
  localparam int N_SYM         = 6;
  localparam int N_SAMPLES     = 2 * N_SYM;
  localparam int N_DIS         = 4;                          // Strobes while disabled
  localparam int TOTAL_SAMPLES = N_DIS + 2 * N_SAMPLES + 1;  // Two golden runs plus one spare
  localparam int WATCH_CYCLES  = TOTAL_SAMPLES * 5 + 100;

  logic                    clk;
  logic                    rst_n;
  logic                    en_rx;
  logic                    valid;
  sample_t                 data_I;
  sample_t                 data_Q;
  logic                    sym_valid;
  dec_t                    dec_I;
  dec_t                    dec_Q;
  err_t                    err_I;
  err_t                    err_Q;
  fse_tap_t [NUM_TAPS-1:0] taps_I;
  fse_tap_t [NUM_TAPS-1:0] taps_Q;

  // Golden data
  int g_x_I [N_SAMPLES];
  int g_x_Q [N_SAMPLES];
  int g_dec_I [N_SYM];
  int g_dec_Q [N_SYM];
  int g_err_I [N_SYM];
  int g_err_Q [N_SYM];
  int g_tap_I [N_SYM][NUM_TAPS];
  int g_tap_Q [N_SYM][NUM_TAPS];

  int          cyc = 0;
  logic [31:0] rng_state = 32'hfe05;
  int          sym_cyc[$];  // Strobe cycle of each closing sample, for the slicer check
  int          sym_idx[$];
  int          tap_cyc[$];  // Same list for the tap check one cycle later
  int          tap_idx[$];

  tb_clock #(.RST_CYCLES(16)) u_clock (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  fse_top #(.NUM_TAPS(NUM_TAPS), .STEP(12'sd1), .LEAK(11'sd1)) dut (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_en_rx     (en_rx),
    .i_valid     (valid),
    .i_data_I    (data_I),
    .i_data_Q    (data_Q),
    .o_sym_valid (sym_valid),
    .o_dec_I     (dec_I),
    .o_dec_Q     (dec_Q),
    .o_err_I     (err_I),
    .o_err_Q     (err_Q),
    .o_taps_I    (taps_I),
    .o_taps_Q    (taps_Q)
  );

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    if (exp !== act) begin
      fail_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic load_golden();
    int    fd;
    int    code;
    int    ns;
    int    nt;
    string line;
    int    a [8];
    int    t [18];
    ns = 0;
    nt = 0;
    fd = $fopen("testbench/fse_golden.txt", "r");
    if (fd == 0) begin
      fail_run("Cannot open the golden file testbench/fse_golden.txt");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line.getc(0) == "#") continue;
      if (line.getc(0) == "s") begin
        code = $sscanf(line, "s %d %d %d %d %d %d %d %d",
                       a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7]);
        if (code != 8 || ns >= N_SYM) fail_run("Bad sample line in the golden file");
        g_x_I[2*ns]   = a[0];
        g_x_Q[2*ns]   = a[1];
        g_x_I[2*ns+1] = a[2];
        g_x_Q[2*ns+1] = a[3];
        g_dec_I[ns]   = a[4];
        g_dec_Q[ns]   = a[5];
        g_err_I[ns]   = a[6];
        g_err_Q[ns]   = a[7];
        ns++;
      end else if (line.getc(0) == "t") begin
        code = $sscanf(line, "t %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                       t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8],
                       t[9], t[10], t[11], t[12], t[13], t[14], t[15], t[16], t[17]);
        if (code != 18 || nt >= N_SYM) fail_run("Bad tap line in the golden file");
        for (int k = 0; k < NUM_TAPS; k++) begin
          g_tap_I[nt][k] = t[k];
          g_tap_Q[nt][k] = t[k + NUM_TAPS];
        end
        nt++;
      end
    end
    $fclose(fd);
    if (ns != N_SYM || nt != N_SYM) fail_run("The golden file holds too few symbols");
  endtask

  task automatic check_taps(input string name, input int idx);
    for (int k = 0; k < NUM_TAPS; k++) begin
      check_value($sformatf("%s tap_I[%0d]", name, k), g_tap_I[idx][k], int'(taps_I[k]));
      check_value($sformatf("%s tap_Q[%0d]", name, k), g_tap_Q[idx][k], int'(taps_Q[k]));
    end
  endtask

  // Reset taps are 1+j0 at the centre in S(10,7)
  task automatic check_reset_taps(input string name);
    for (int k = 0; k < NUM_TAPS; k++) begin
      check_value($sformatf("%s tap_I[%0d]", name, k), (k == MID_IDX) ? 128 : 0,
                  int'(taps_I[k]));
      check_value($sformatf("%s tap_Q[%0d]", name, k), 0, int'(taps_Q[k]));
    end
  endtask

  // idx is the symbol that this sample closes, or -1
  task automatic send_sample(input int xi, input int xq, input int idx);
    int gap;
    @(posedge clk);
    #1;
    valid  = 1'b1;
    data_I = sample_t'(xi);
    data_Q = sample_t'(xq);
    if (idx >= 0) begin
      sym_cyc.push_back(cyc);
      sym_idx.push_back(idx);
      tap_cyc.push_back(cyc);
      tap_idx.push_back(idx);
    end
    @(posedge clk);
    #1;
    valid = 1'b0;
    rng_state = xorshift32(rng_state);
    gap = 1 + int'(rng_state % 3);  // 1 to 3 idle cycles
    repeat (gap - 1) @(posedge clk);
  endtask

  task automatic run_golden();
    for (int s = 0; s < N_SAMPLES; s++) begin
      send_sample(g_x_I[s], g_x_Q[s], (s % 2 == 1) ? s / 2 : -1);
    end
  endtask

  task automatic drain();
    while (sym_cyc.size() > 0 || tap_cyc.size() > 0) @(posedge clk);
  endtask

  // Outputs are read mid-cycle, away from the edges
  always @(negedge clk) begin : monitor
    int idx;
    if (rst_n) begin
      if (sym_cyc.size() > 0 && sym_cyc[0] == cyc - 3) begin
        void'(sym_cyc.pop_front());
        idx = sym_idx.pop_front();
        check_value($sformatf("symbol %0d valid", idx), 1, int'(sym_valid));
        check_value($sformatf("symbol %0d dec_I", idx), g_dec_I[idx], int'(dec_I));
        check_value($sformatf("symbol %0d dec_Q", idx), g_dec_Q[idx], int'(dec_Q));
        check_value($sformatf("symbol %0d err_I", idx), g_err_I[idx], int'(err_I));
        check_value($sformatf("symbol %0d err_Q", idx), g_err_Q[idx], int'(err_Q));
      end else begin
        check_value($sformatf("idle valid at cycle %0d", cyc), 0, int'(sym_valid));
      end
      if (tap_cyc.size() > 0 && tap_cyc[0] == cyc - 4) begin
        void'(tap_cyc.pop_front());
        idx = tap_idx.pop_front();
        check_taps($sformatf("symbol %0d", idx), idx);
      end
    end
  end

  initial begin : watchdog
    repeat (WATCH_CYCLES) @(posedge clk);
    fail_run("Timeout: the symbol outputs stopped before all checks were done");
  end

  initial begin : stimulus
    en_rx  = 1'b1;
    valid  = 1'b0;
    data_I = '0;
    data_Q = '0;
    load_golden();
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_reset_taps("after reset");

    // Strobes with the receiver off
    @(posedge clk);
    #1 en_rx = 1'b0;
    for (int i = 0; i < N_DIS; i++) begin
      rng_state = xorshift32(rng_state);
      send_sample(int'($signed(rng_state[7:0])), int'($signed(rng_state[15:8])), -1);
    end
    repeat (6) @(posedge clk);
    @(negedge clk);
    check_reset_taps("rx disabled");
    @(posedge clk);
    #1 en_rx = 1'b1;

    run_golden();
    drain();

    // Leave the phase odd, then drop the receiver mid-run
    send_sample(40, -40, -1);
    @(posedge clk);
    #1 en_rx = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_reset_taps("rx dropped");
    @(posedge clk);
    #1 en_rx = 1'b1;

    run_golden();
    drain();
    repeat (4) @(posedge clk);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/fse_golden.txt */
# s: even I, even Q, odd I, odd Q, then expected dec I, dec Q, err I, err Q
# t: exported taps after that symbol's update, tap_I[0..8] then tap_Q[0..8]
# Symbol 0
s 64 64 48 40 64 64 -64 -64
t 0 0 0 0 127 0 0 0 0 0 0 0 0 0 0 0 0 0
# Symbol 1
s -64 64 -50 44 64 64 -64 -64
t 0 0 0 0 127 0 0 0 0 -1 -1 0 0 0 0 0 0 0
# Symbol 2
s 64 -64 56 -60 64 64 -17 -25
t 0 0 0 0 128 0 0 0 0 -1 -1 -1 -1 0 0 0 0 0
# Symbol 3
s -64 -64 -40 -52 -64 64 12 -20
t 0 0 0 0 128 0 0 0 0 -1 -1 -1 -1 0 -1 0 0 0
# Symbol 4
s 64 64 60 70 64 -64 -8 3
t 0 0 0 0 128 0 -1 -1 0 -1 -1 -1 -1 0 0 0 0 -1
# Symbol 5
s -64 64 -58 46 -64 -64 25 13
t 0 0 0 0 128 0 -1 -1 0 -1 -1 0 -1 -1 -1 -1 -1 0

/* project.f */
src/fse_fmt_pkg.sv
src/fse_ctrl_pkg.sv
src/fse_ifs.sv
src/fse_rate_ctrl.sv
src/fse_filter.sv
src/fse_slicer.sv
src/lms_update.sv
src/fse_top.sv
testbench/tb_clock.sv
testbench/tb_fse.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fse -f project.f -o Vtb_fse
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_fse 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
